// ==== hdl/mem_port_mux.sv ====
// top of the shared memory port for dcache, bypass and icache
// arbitrates AR and AW, orders W by accepted AW, routes R and B by ID
`timescale 1ns/1ps

module mem_port_mux (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    // source side, index by SRC_*
    input  logic [mem_port_pkg::N_SRC-1:0] ar_valid_i,
    input  mem_port_pkg::axi_id_t          ar_id_i [mem_port_pkg::N_SRC],
    input  mem_port_pkg::addr_t            ar_addr_i [mem_port_pkg::N_SRC],
    output logic [mem_port_pkg::N_SRC-1:0] ar_ready_o,
    input  logic [mem_port_pkg::N_SRC-1:0] aw_valid_i,
    input  mem_port_pkg::axi_id_t          aw_id_i [mem_port_pkg::N_SRC],
    input  mem_port_pkg::addr_t            aw_addr_i [mem_port_pkg::N_SRC],
    output logic [mem_port_pkg::N_SRC-1:0] aw_ready_o,
    input  logic [mem_port_pkg::N_SRC-1:0] w_valid_i,
    input  mem_port_pkg::data_t            w_data_i [mem_port_pkg::N_SRC],
    input  logic [mem_port_pkg::N_SRC-1:0] w_last_i,
    output logic [mem_port_pkg::N_SRC-1:0] w_ready_o,
    output logic [mem_port_pkg::N_SRC-1:0] r_valid_o,
    input  logic [mem_port_pkg::N_SRC-1:0] r_ready_i,
    output logic [mem_port_pkg::N_SRC-1:0] b_valid_o,
    input  logic [mem_port_pkg::N_SRC-1:0] b_ready_i,
    // broadcast response payload
    output mem_port_pkg::axi_id_t          r_id_o,
    output mem_port_pkg::data_t            r_data_o,
    output logic                           r_last_o,
    output mem_port_pkg::axi_id_t          b_id_o,
    output mem_port_pkg::resp_t            b_resp_o,
    // memory side
    output logic                           mem_ar_valid_o,
    output mem_port_pkg::axi_id_t          mem_ar_id_o,
    output mem_port_pkg::addr_t            mem_ar_addr_o,
    input  logic                           mem_ar_ready_i,
    output logic                           mem_aw_valid_o,
    output mem_port_pkg::axi_id_t          mem_aw_id_o,
    output mem_port_pkg::addr_t            mem_aw_addr_o,
    input  logic                           mem_aw_ready_i,
    output logic                           mem_w_valid_o,
    output mem_port_pkg::data_t            mem_w_data_o,
    output logic                           mem_w_last_o,
    input  logic                           mem_w_ready_i,
    input  logic                           mem_r_valid_i,
    input  mem_port_pkg::axi_id_t          mem_r_id_i,
    input  mem_port_pkg::data_t            mem_r_data_i,
    input  logic                           mem_r_last_i,
    output logic                           mem_r_ready_o,
    input  logic                           mem_b_valid_i,
    input  mem_port_pkg::axi_id_t          mem_b_id_i,
    input  mem_port_pkg::resp_t            mem_b_resp_i,
    output logic                           mem_b_ready_o
);
    import mem_port_pkg::*;

    logic    aw_arb_valid; // arbiter to write route control
    axi_id_t aw_arb_id;
    addr_t   aw_arb_addr;
    logic    aw_arb_ready;

    // --------------------------------------------------
    // address arbitration
    // --------------------------------------------------
    req_arbiter i_ar_arbiter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (ar_valid_i),
        .req_id_i    (ar_id_i),
        .req_addr_i  (ar_addr_i),
        .req_ready_o (ar_ready_o),
        .out_valid_o (mem_ar_valid_o),
        .out_id_o    (mem_ar_id_o),
        .out_addr_o  (mem_ar_addr_o),
        .out_ready_i (mem_ar_ready_i)
    );

    req_arbiter i_aw_arbiter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (aw_valid_i),
        .req_id_i    (aw_id_i),
        .req_addr_i  (aw_addr_i),
        .req_ready_o (aw_ready_o),
        .out_valid_o (aw_arb_valid),
        .out_id_o    (aw_arb_id),
        .out_addr_o  (aw_arb_addr),
        .out_ready_i (aw_arb_ready)
    );

    write_route_ctrl i_write_route_ctrl (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .aw_valid_i     (aw_arb_valid),
        .aw_id_i        (aw_arb_id),
        .aw_addr_i      (aw_arb_addr),
        .aw_ready_o     (aw_arb_ready),
        .mem_aw_valid_o (mem_aw_valid_o),
        .mem_aw_id_o    (mem_aw_id_o),
        .mem_aw_addr_o  (mem_aw_addr_o),
        .mem_aw_ready_i (mem_aw_ready_i),
        .src_w_valid_i  (w_valid_i),
        .src_w_data_i   (w_data_i),
        .src_w_last_i   (w_last_i),
        .src_w_ready_o  (w_ready_o),
        .mem_w_valid_o  (mem_w_valid_o),
        .mem_w_data_o   (mem_w_data_o),
        .mem_w_last_o   (mem_w_last_o),
        .mem_w_ready_i  (mem_w_ready_i)
    );

    // --------------------------------------------------
    // responses, payload to everyone
    // --------------------------------------------------
    assign r_id_o   = mem_r_id_i;
    assign r_data_o = mem_r_data_i;
    assign r_last_o = mem_r_last_i;
    assign b_id_o   = mem_b_id_i;
    assign b_resp_o = mem_b_resp_i;

    resp_router i_r_router (
        .in_valid_i  (mem_r_valid_i),
        .in_id_i     (mem_r_id_i),
        .in_ready_o  (mem_r_ready_o),
        .out_valid_o (r_valid_o),
        .out_ready_i (r_ready_i),
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i)
    );

    resp_router i_b_router (
        .in_valid_i  (mem_b_valid_i),
        .in_id_i     (mem_b_id_i),
        .in_ready_o  (mem_b_ready_o),
        .out_valid_o (b_valid_o),
        .out_ready_i (b_ready_i),
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i)
    );

endmodule

// ==== hdl/mem_port_pkg.sv ====
// shared types, ID encodings and source indices for the memory port mux
// every design module imports this package inside its body
package mem_port_pkg;

    // --------------------------------------------------
    // payload widths
    // --------------------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [63:0] data_t;
    typedef logic [1:0]  resp_t;
    typedef logic [1:0]  src_sel_t;

    // source slots, lower index wins first after reset
    localparam int       N_SRC      = 3;
    localparam src_sel_t SRC_DCACHE = 2'd0;
    localparam src_sel_t SRC_BYPASS = 2'd1;
    localparam src_sel_t SRC_ICACHE = 2'd2;

    // fixed IDs per requester
    localparam axi_id_t ID_ICACHE      = 4'b0000;
    localparam axi_id_t ID_DCACHE      = 4'b1100;
    localparam axi_id_t ID_BYPASS_BASE = 4'b1000; // 10xx, four IDs

    // write addresses still waiting for their data
    localparam int W_QUEUE_DEPTH = 4;

    // unknown IDs fall back to the dcache slot
    function automatic src_sel_t id_to_src(axi_id_t id);
        src_sel_t src;
        if (id == ID_ICACHE) begin
            src = SRC_ICACHE;
        end else if (id[3:2] == ID_BYPASS_BASE[3:2]) begin
            src = SRC_BYPASS;
        end else begin
            src = SRC_DCACHE;
        end
        return src;
    endfunction

endpackage

// ==== hdl/req_arbiter.sv ====
// round-robin arbiter for three address requesters onto one port
// the grant is held until the downstream side accepts the offer
`timescale 1ns/1ps

module req_arbiter (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic [mem_port_pkg::N_SRC-1:0] req_valid_i,
    input  mem_port_pkg::axi_id_t          req_id_i [mem_port_pkg::N_SRC],
    input  mem_port_pkg::addr_t            req_addr_i [mem_port_pkg::N_SRC],
    output logic [mem_port_pkg::N_SRC-1:0] req_ready_o,
    output logic                           out_valid_o,
    output mem_port_pkg::axi_id_t          out_id_o,
    output mem_port_pkg::addr_t            out_addr_o,
    input  logic                           out_ready_i
);
    import mem_port_pkg::*;

    src_sel_t rr_ptr_q;  // first slot searched
    src_sel_t grant_q;
    logic     lock_q;    // offer pending, keep grant_q
    src_sel_t rr_pick;
    src_sel_t grant;
    logic     xfer;

    // first valid source at or after the pointer
    always_comb begin
        int idx;
        logic found;
        rr_pick = rr_ptr_q;
        found   = 1'b0;
        for (int i = 0; i < N_SRC; i++) begin
            idx = (int'(rr_ptr_q) + i) % N_SRC;
            if (!found && req_valid_i[idx]) begin
                rr_pick = src_sel_t'(idx);
                found   = 1'b1;
            end
        end
    end

    assign grant       = lock_q ? grant_q : rr_pick;
    assign out_valid_o = req_valid_i[grant];
    assign out_id_o    = req_id_i[grant];
    assign out_addr_o  = req_addr_i[grant];
    assign xfer        = out_valid_o & out_ready_i;

    always_comb begin
        req_ready_o        = '0;
        req_ready_o[grant] = xfer; // only the granted source
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_ptr_q <= SRC_DCACHE;
            grant_q  <= SRC_DCACHE;
            lock_q   <= 1'b0;
        end else begin
            lock_q  <= out_valid_o & ~out_ready_i;
            grant_q <= grant;
            if (xfer) begin
                rr_ptr_q <= (grant == src_sel_t'(N_SRC - 1)) ? '0 : src_sel_t'(grant + 2'd1);
            end
        end
    end

    a_offer_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_id_o) && $stable(out_addr_o))
        else $error("arbiter offer changed before it was accepted");

    for (genvar s = 0; s < N_SRC; s++) begin : g_id_chk
        a_src_id: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            req_valid_i[s] |-> id_to_src(req_id_i[s]) == src_sel_t'(s)
                && (src_sel_t'(s) != SRC_DCACHE || req_id_i[s] == ID_DCACHE))
            else $error("source %0d offered unexpected ID %4b", s, req_id_i[s]);
    end

endmodule

// ==== hdl/resp_router.sv ====
// steers a response valid to one source by transaction ID
// only valid and ready pass through here as payload is broadcast elsewhere
`timescale 1ns/1ps

module resp_router (
    input  logic                           in_valid_i,
    input  mem_port_pkg::axi_id_t          in_id_i,
    output logic                           in_ready_o,
    output logic [mem_port_pkg::N_SRC-1:0] out_valid_o,
    input  logic [mem_port_pkg::N_SRC-1:0] out_ready_i,
    input  logic                           clk_i,
    input  logic                           rst_n_i
);
    import mem_port_pkg::*;

    src_sel_t dst_sel;

    assign dst_sel = id_to_src(in_id_i);

    // --------------------------------------------------
    // one-hot valid and ready from the addressed source
    // --------------------------------------------------
    always_comb begin
        out_valid_o          = '0;
        out_valid_o[dst_sel] = in_valid_i;
    end

    assign in_ready_o = out_ready_i[dst_sel];

    a_dst_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_valid_i && !in_ready_o |=> $stable(out_valid_o))
        else $error("stalled response moved to another source");

endmodule

// ==== hdl/write_route_ctrl.sv ====
// forwards granted write addresses and steers write data in AW order
// a small queue of source selects replaces the missing WID
`timescale 1ns/1ps

module write_route_ctrl (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           aw_valid_i,
    input  mem_port_pkg::axi_id_t          aw_id_i,
    input  mem_port_pkg::addr_t            aw_addr_i,
    output logic                           aw_ready_o,
    output logic                           mem_aw_valid_o,
    output mem_port_pkg::axi_id_t          mem_aw_id_o,
    output mem_port_pkg::addr_t            mem_aw_addr_o,
    input  logic                           mem_aw_ready_i,
    input  logic [mem_port_pkg::N_SRC-1:0] src_w_valid_i,
    input  mem_port_pkg::data_t            src_w_data_i [mem_port_pkg::N_SRC],
    input  logic [mem_port_pkg::N_SRC-1:0] src_w_last_i,
    output logic [mem_port_pkg::N_SRC-1:0] src_w_ready_o,
    output logic                           mem_w_valid_o,
    output mem_port_pkg::data_t            mem_w_data_o,
    output logic                           mem_w_last_o,
    input  logic                           mem_w_ready_i
);
    import mem_port_pkg::*;

    typedef logic [$clog2(W_QUEUE_DEPTH)-1:0] q_ptr_t; // wraps naturally with power-of-two depth
    typedef logic [$clog2(W_QUEUE_DEPTH):0]   q_cnt_t;

    src_sel_t sel_mem_q [W_QUEUE_DEPTH];
    q_ptr_t   wr_ptr_q;
    q_ptr_t   rd_ptr_q;
    q_cnt_t   count_q;
    logic     q_full;
    logic     q_empty;
    logic     push;
    logic     pop;
    src_sel_t w_sel;

    assign q_full  = (count_q == q_cnt_t'(W_QUEUE_DEPTH));
    assign q_empty = (count_q == '0);

    // --------------------------------------------------
    // write address held back while the queue is full
    // --------------------------------------------------
    assign mem_aw_valid_o = aw_valid_i & ~q_full;
    assign mem_aw_id_o    = aw_id_i;
    assign mem_aw_addr_o  = aw_addr_i;
    assign aw_ready_o     = mem_aw_ready_i & ~q_full;

    assign push = mem_aw_valid_o & mem_aw_ready_i;
    assign pop  = mem_w_valid_o & mem_w_ready_i & mem_w_last_o; // burst done

    always_ff @(posedge clk_i) begin
        if (push) begin
            sel_mem_q[wr_ptr_q] <= id_to_src(mem_aw_id_o);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // write data mux with icache parked on it when idle
    // --------------------------------------------------
    assign w_sel         = q_empty ? SRC_ICACHE : sel_mem_q[rd_ptr_q];
    assign mem_w_valid_o = src_w_valid_i[w_sel];
    assign mem_w_data_o  = src_w_data_i[w_sel];
    assign mem_w_last_o  = src_w_last_i[w_sel];

    always_comb begin
        src_w_ready_o        = '0;
        src_w_ready_o[w_sel] = mem_w_ready_i & src_w_valid_i[w_sel];
    end

    // icache write data would slip through here
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop |-> !q_empty)
        else $error("write burst completed with no address queued");

endmodule

// ==== mem_port_mux.f ====
hdl/mem_port_pkg.sv
hdl/req_arbiter.sv
hdl/write_route_ctrl.sv
hdl/resp_router.sv
hdl/mem_port_mux.sv
sim/tb_mem_port_mux.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mem_port_mux.f \
    --top-module tb_mem_port_mux -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1

// ==== sim/mem_port_testdata.txt ====
// op src id beats route seed addr, one step per line
// op 1 read, 2 read round, 3 stalled read, 4 aw, 5 w drain, 6 r beat, 7 b resp
1_0_C_1_0_000_00001000
1_1_9_1_1_000_20000040
1_2_0_1_2_000_00004000
2_0_A_0_0_000_00010000
3_1_8_5_1_000_30000000
3_0_C_3_0_000_00002000
3_2_0_2_2_000_00005000
4_1_8_2_0_0A1_40000000
4_0_C_3_0_0B2_00003000
4_1_B_1_0_0C3_40000100
5_0_0_0_0_000_00000000
4_0_C_4_0_0D4_00003100
4_1_9_2_0_0E5_40000200
4_0_C_1_0_0F6_00003200
4_1_A_3_0_107_40000300
5_0_0_1_0_000_00000000
4_1_8_4_0_218_40000400
4_1_B_1_0_229_40000500
4_0_C_2_0_23A_00003300
5_0_0_1_0_000_00000000
6_0_0_2_2_011_00000000
6_0_9_0_1_022_00000000
6_0_C_3_0_033_00000000
6_0_B_1_1_044_00000000
7_0_B_1_1_002_00000000
7_0_C_0_0_001_00000000
7_0_6_2_0_003_00000000

// ==== sim/tb_mem_port_mux.sv ====
// testbench for the shared memory port driven by steps from the testdata file
// models the three sources and the memory side and checks routing and order
`timescale 1ns/1ps

module tb_mem_port_mux;
    import mem_port_pkg::*;

    localparam int PERIOD = 20;
    localparam int MAX_STEPS = 64;
    localparam int WD_CYCLES = 200; // per step

    logic clk_i = 1'b0;
    logic rst_n_i;
    logic [2:0] ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o, w_valid_i, w_last_i, w_ready_o;
    logic [2:0] r_valid_o, r_ready_i, b_valid_o, b_ready_i;
    axi_id_t ar_id_i [3], aw_id_i [3];
    addr_t ar_addr_i [3], aw_addr_i [3];
    data_t w_data_i [3];
    axi_id_t r_id_o, b_id_o, mem_ar_id_o, mem_aw_id_o, mem_r_id_i, mem_b_id_i;
    data_t r_data_o, mem_w_data_o, mem_r_data_i;
    resp_t b_resp_o, mem_b_resp_i;
    addr_t mem_ar_addr_o, mem_aw_addr_o;
    logic r_last_o, mem_ar_valid_o, mem_ar_ready_i, mem_aw_valid_o, mem_aw_ready_i;
    logic mem_w_valid_o, mem_w_last_o, mem_w_ready_i, mem_r_valid_i, mem_r_last_i;
    logic mem_r_ready_o, mem_b_valid_i, mem_b_ready_o;

    logic [63:0] steps [MAX_STEPS];
    int n_steps, errors, tests, failed, n_bursts;
    logic loaded = 1'b0;
    logic step_bad;
    integer seed = 32'h1cc8;
    // issued bursts in AW order
    int b_src [64], b_beats [64];
    addr_t b_addr [64];
    logic [11:0] b_seed [64];
    int order_q [$];
    int beat_cnt [3];

    mem_port_mux DUT (.*);

    always #(PERIOD / 2) clk_i = ~clk_i;

    initial begin
        wait (loaded);
        #(n_steps * WD_CYCLES * PERIOD);
        $display("watchdog expired, the DUT stopped responding");
        $display("** FAIL **");
        $finish;
    end

    // sample point just ahead of the rising edge
    task automatic settle();
        #(PERIOD / 2 - 1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error @%0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
            step_bad = 1'b1;
        end
    endtask

    function automatic data_t wdata(int idx, int beat);
        return {b_addr[idx], b_seed[idx], 16'h0, 4'(beat)};
    endfunction

    // one AR offer with memory stalled for the given number of cycles first
    task automatic do_read(int src, axi_id_t id, addr_t addr, int stall);
        @(negedge clk_i);
        ar_valid_i[src] = 1'b1;
        ar_id_i[src]    = id;
        ar_addr_i[src]  = addr;
        mem_ar_ready_i  = 1'b0;
        repeat (stall) begin
            settle();
            check_val("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'd1);
            check_val("mem_ar_id_o", 64'(mem_ar_id_o), 64'(id));
            check_val("mem_ar_addr_o", 64'(mem_ar_addr_o), 64'(addr));
            check_val("ar_ready_o", 64'(ar_ready_o), 64'd0);
            @(negedge clk_i);
            ar_valid_i = '1; // competing requests must not steal the grant
        end
        mem_ar_ready_i = 1'b1;
        settle();
        check_val("mem_ar_id_o", 64'(mem_ar_id_o), 64'(id));
        check_val("mem_ar_addr_o", 64'(mem_ar_addr_o), 64'(addr));
        check_val("ar_ready_o", 64'(ar_ready_o), 64'(3'(1) << src));
        @(negedge clk_i);
        ar_valid_i = '0;
    endtask

    // all sources ask at once for two rounds starting from slot 0
    task automatic read_round(axi_id_t bp_id, addr_t base);
        @(negedge clk_i);
        ar_valid_i = 3'b111;
        ar_id_i[SRC_DCACHE] = ID_DCACHE;
        ar_id_i[SRC_BYPASS] = bp_id;
        ar_id_i[SRC_ICACHE] = ID_ICACHE;
        for (int s = 0; s < 3; s++) ar_addr_i[s] = base + addr_t'(s * 'h100);
        mem_ar_ready_i = 1'b1;
        for (int n = 0; n < 6; n++) begin
            settle();
            check_val("mem_ar_id_o", 64'(mem_ar_id_o), 64'(ar_id_i[n % 3]));
            check_val("mem_ar_addr_o", 64'(mem_ar_addr_o), 64'(ar_addr_i[n % 3]));
            check_val("ar_ready_o", 64'(ar_ready_o), 64'(3'(1) << (n % 3)));
            @(negedge clk_i);
        end
        ar_valid_i = '0;
    endtask

    task automatic issue_aw(int src, axi_id_t id, addr_t addr, int beats, logic [11:0] sd);
        @(negedge clk_i);
        aw_valid_i[src] = 1'b1;
        aw_id_i[src]    = id;
        aw_addr_i[src]  = addr;
        mem_aw_ready_i  = 1'b1;
        settle();
        while (!aw_ready_o[src]) begin
            @(negedge clk_i);
            settle();
        end
        check_val("mem_aw_valid_o", 64'(mem_aw_valid_o), 64'd1);
        check_val("mem_aw_id_o", 64'(mem_aw_id_o), 64'(id));
        check_val("mem_aw_addr_o", 64'(mem_aw_addr_o), 64'(addr));
        b_src[n_bursts]   = src;
        b_beats[n_bursts] = beats;
        b_addr[n_bursts]  = addr;
        b_seed[n_bursts]  = sd;
        order_q.push_back(n_bursts);
        n_bursts++;
        @(negedge clk_i);
        aw_valid_i = '0;
    endtask

    // every source offers its oldest burst and memory must take them in AW order
    task automatic drain_w(logic stall);
        int head;
        int hs;
        logic found;
        while (order_q.size() > 0) begin
            @(negedge clk_i);
            for (int s = 0; s < 3; s++) begin
                found        = 1'b0;
                w_valid_i[s] = 1'b0;
                foreach (order_q[k]) begin
                    if (!found && b_src[order_q[k]] == s) begin
                        found        = 1'b1;
                        w_valid_i[s] = 1'b1;
                        w_data_i[s]  = wdata(order_q[k], beat_cnt[s]);
                        w_last_i[s]  = (beat_cnt[s] == b_beats[order_q[k]] - 1);
                    end
                end
            end
            mem_w_ready_i = stall ? 1'($random(seed)) : 1'b1;
            settle();
            head = order_q[0];
            hs   = b_src[head];
            if (mem_w_ready_i) begin
                check_val("mem_w_valid_o", 64'(mem_w_valid_o), 64'd1);
                check_val("mem_w_data_o", mem_w_data_o, wdata(head, beat_cnt[hs]));
                check_val("mem_w_last_o", 64'(mem_w_last_o),
                          64'(beat_cnt[hs] == b_beats[head] - 1));
                check_val("w_ready_o", 64'(w_ready_o), 64'(3'(1) << hs));
                beat_cnt[hs]++;
                if (beat_cnt[hs] == b_beats[head]) begin
                    beat_cnt[hs] = 0;
                    void'(order_q.pop_front());
                end
            end else begin
                check_val("w_ready_o", 64'(w_ready_o), 64'd0);
            end
        end
        @(negedge clk_i);
        w_valid_i     = '0;
        mem_w_ready_i = 1'b0;
    endtask

    // R or B beat while the routed source holds ready low for a while
    task automatic send_resp(logic is_b, axi_id_t id, int stall, int route, logic [11:0] sd);
        data_t rd;
        rd = {4'hd, 48'h0, sd};
        @(negedge clk_i);
        mem_r_valid_i = !is_b;
        mem_b_valid_i = is_b;
        mem_r_id_i    = id;
        mem_b_id_i    = id;
        mem_r_data_i  = rd;
        mem_r_last_i  = sd[0];
        mem_b_resp_i  = sd[1:0];
        r_ready_i     = ~(3'(1) << route); // ready of the other sources must not matter
        b_ready_i     = ~(3'(1) << route);
        for (int n = 0; n <= stall; n++) begin
            if (n == stall) begin
                r_ready_i = '1;
                b_ready_i = '1;
            end
            settle();
            if (is_b) begin
                check_val("b_valid_o", 64'(b_valid_o), 64'(3'(1) << route));
                check_val("b_resp_o", 64'(b_resp_o), 64'(sd[1:0]));
                check_val("b_id_o", 64'(b_id_o), 64'(id));
                check_val("mem_b_ready_o", 64'(mem_b_ready_o), 64'(n == stall));
            end else begin
                check_val("r_valid_o", 64'(r_valid_o), 64'(3'(1) << route));
                check_val("r_data_o", r_data_o, rd);
                check_val("r_id_o", 64'(r_id_o), 64'(id));
                check_val("r_last_o", 64'(r_last_o), 64'(sd[0]));
                check_val("mem_r_ready_o", 64'(mem_r_ready_o), 64'(n == stall));
            end
            @(negedge clk_i);
        end
        mem_r_valid_i = 1'b0;
        mem_b_valid_i = 1'b0;
    endtask

    initial begin
        int op;
        rst_n_i = 1'b0;
        ar_valid_i = '0;
        aw_valid_i = '0;
        w_valid_i = '0;
        w_last_i = '0;
        r_ready_i = '0;
        b_ready_i = '0;
        for (int s = 0; s < 3; s++) begin
            ar_id_i[s] = '0;
            ar_addr_i[s] = '0;
            aw_id_i[s] = '0;
            aw_addr_i[s] = '0;
            w_data_i[s] = '0;
            beat_cnt[s] = 0;
        end
        mem_ar_ready_i = 1'b0;
        mem_aw_ready_i = 1'b0;
        mem_w_ready_i = 1'b0;
        mem_r_valid_i = 1'b0;
        mem_r_id_i = '0;
        mem_r_data_i = '0;
        mem_r_last_i = 1'b0;
        mem_b_valid_i = 1'b0;
        mem_b_id_i = '0;
        mem_b_resp_i = '0;
        for (int i = 0; i < MAX_STEPS; i++) steps[i] = '0;
        $readmemh("sim/mem_port_testdata.txt", steps);
        n_steps = 0;
        while (n_steps < MAX_STEPS && steps[n_steps][63:60] != 4'h0) n_steps++;
        loaded = 1'b1;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        for (int i = 0; i < n_steps; i++) begin
            step_bad = 1'b0;
            op = int'(steps[i][63:60]);
            case (op)
                1, 3: do_read(int'(steps[i][59:56]), steps[i][55:52], steps[i][31:0],
                              (op == 3) ? int'(steps[i][51:48]) : 0);
                2: read_round(steps[i][55:52], steps[i][31:0]);
                4: issue_aw(int'(steps[i][59:56]), steps[i][55:52], steps[i][31:0],
                            int'(steps[i][51:48]), steps[i][43:32]);
                5: drain_w(steps[i][51:48] != 4'h0);
                6, 7: send_resp(op == 7, steps[i][55:52], int'(steps[i][51:48]),
                                int'(steps[i][47:44]), steps[i][43:32]);
                default: begin
                    $display("step %0d has an unknown operation %0d", i, op);
                    errors++;
                    step_bad = 1'b1;
                end
            endcase
            tests++;
            if (step_bad) failed++;
            $display("step %0d op %0d: %s", i, op, step_bad ? "failed" : "ok");
        end
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
